//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module pipeTb -f sources.f -o pipeSim \
    && ./obj_dir/pipeSim | tee sim.log \
    || { echo "Build or simulation did not run"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sources.f
src/pipePkg.sv
src/fetchUnit.sv
src/decodeStage.sv
src/execStage.sv
src/memStage.sv
src/writebackStage.sv
src/hazardUnit.sv
src/pipeTop.sv
verif/pipeTb.sv

//--- src/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic            clk,
    input  logic            reset,
    input  logic            stallD,
    input  logic            flushD,
    input  pipePkg::slot_t  slotIn,
    output pipePkg::slot_t  slotOut,
    output logic            branchD,
    output pipePkg::pc_t    targetD
);
    import pipePkg::*;

    ctrlFields_t ctrl;

    always_ff @(posedge clk) begin
        if (reset || flushD) begin
            slotOut <= bubbleSlot;
        end else if (!stallD) begin
            slotOut <= slotIn;
        end
    end

    assign ctrl = slotOut.instr.ctrl;

    // Jumps are unconditional, so they resolve here without waiting for M
    assign branchD = slotOut.valid && (ctrl.opcode == JUMP);
    assign targetD = slotOut.pc + pc_t'(ctrl.offset);

endmodule

//--- src/execStage.sv
`timescale 1ns/1ps

module execStage (
    input  logic            clk,
    input  logic            reset,
    input  logic            stallE,
    input  logic            flushE,
    input  pipePkg::slot_t  slotIn,
    output pipePkg::slot_t  slotOut,
    output logic            eWait
);
    import pipePkg::*;

    aluFields_t aluIn;
    logic [1:0] count;

    assign aluIn = slotIn.instr.alu;

    always_ff @(posedge clk) begin
        if (reset || flushE) begin
            slotOut <= bubbleSlot;
            count   <= '0;
        end else if (!stallE) begin
            slotOut <= slotIn;
            // Latency counts the extra cycles beyond the first one in E
            if (slotIn.valid && (aluIn.opcode == ALU)) begin
                count <= aluIn.latency;
            end else begin
                count <= '0;
            end
        end else if (count != '0) begin
            count <= count - 2'd1;
        end
    end

    // The countdown keeps running while a load in M holds everything up
    assign eWait = (count != '0);

endmodule

//--- src/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
    input  logic             clk,
    input  logic             reset,
    input  logic             stallF,
    input  logic             flushF2,
    input  logic             redirectD,
    input  pipePkg::pc_t     targetD,
    input  logic             redirectM,
    input  pipePkg::pc_t     targetM,
    input  logic             redirectW,
    output logic             imemReqValid,
    output pipePkg::pc_t     imemReqAddr,
    input  logic             imemReqReady,
    input  logic             imemRespValid,
    input  pipePkg::instr_t  imemRespData,
    output logic             iWait,
    output pipePkg::slot_t   slotF2
);
    import pipePkg::*;

    pc_t    pc;
    pc_t    reqPc;
    logic   pending;
    logic   held;
    instr_t heldWord;
    instr_t respWord;
    logic   redirect;
    logic   respReady;
    logic   accept;
    logic   consume;
    slot_t  fetched;

    assign redirect  = redirectW | redirectM | redirectD;
    // A response that arrived during a stall is parked until F2 can take it
    assign respReady = pending & (held | imemRespValid);
    assign respWord  = held ? heldWord : imemRespData;
    assign iWait     = pending & ~respReady;

    // No request goes out on a redirect cycle, so every accepted fetch is on the new path
    assign imemReqValid = ~pending & ~stallF & ~redirect;
    assign imemReqAddr  = pc;
    assign accept       = imemReqValid & imemReqReady;
    assign consume      = respReady & (flushF2 | ~stallF);

    assign fetched = '{valid: 1'b1, pc: reqPc, instr: respWord};

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= '0;
            pending <= 1'b0;
            held    <= 1'b0;
        end else begin
            // Redirects land even while F is stalled waiting on memory
            if (redirectW) begin
                pc <= trapVector;
            end else if (redirectM) begin
                pc <= targetM;
            end else if (redirectD) begin
                pc <= targetD;
            end else if (accept) begin
                pc <= pc + pc_t'(1);
            end
            if (accept) begin
                pending <= 1'b1;
            end else if (consume) begin
                pending <= 1'b0;
            end
            if (consume) begin
                held <= 1'b0;
            end else if (pending && imemRespValid) begin
                held <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reqPc <= pc;
        end
        if (imemRespValid) begin
            heldWord <= imemRespData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flushF2) begin
            slotF2 <= bubbleSlot;
        end else if (!stallF) begin
            slotF2 <= respReady ? fetched : bubbleSlot;
        end
    end

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  logic clk,
    input  logic reset,
    input  logic branchD,
    input  logic branchM,
    input  logic excpM,
    input  logic excpW,
    input  logic iWait,
    input  logic eWait,
    input  logic dWait,
    output logic stallF,
    output logic flushF2,
    output logic stallD,
    output logic flushD,
    output logic stallE,
    output logic flushE,
    output logic stallM,
    output logic flushM,
    output logic flushW
);

    // Each flag marks a fetch still in flight when the pipe was redirected
    logic excpPend;
    logic excpPendNext;
    logic branchPend;
    logic branchPendNext;
    logic jumpPend;
    logic jumpPendNext;

    always_ff @(posedge clk) begin
        if (reset) begin
            excpPend   <= 1'b0;
            branchPend <= 1'b0;
            jumpPend   <= 1'b0;
        end else begin
            excpPend   <= excpPendNext;
            branchPend <= branchPendNext;
            jumpPend   <= jumpPendNext;
        end
    end

    always_comb begin
        stallF         = 1'b0;
        flushF2        = 1'b0;
        stallD         = 1'b0;
        flushD         = 1'b0;
        stallE         = 1'b0;
        flushE         = 1'b0;
        stallM         = 1'b0;
        flushM         = 1'b0;
        flushW         = 1'b0;
        excpPendNext   = excpPend;
        branchPendNext = branchPend;
        jumpPendNext   = jumpPend;

        if (excpW || excpM) begin
            flushF2 = 1'b1;
            flushD  = 1'b1;
            flushE  = 1'b1;
            flushM  = 1'b1;
            flushW  = excpW;
            if (iWait) begin
                stallF       = 1'b1;
                excpPendNext = 1'b1;
            end
        end else if (dWait) begin
            stallF = 1'b1;
            stallD = 1'b1;
            stallE = 1'b1;
            stallM = 1'b1;
            flushW = 1'b1;
        end else if (branchM) begin
            flushF2 = 1'b1;
            flushD  = 1'b1;
            flushE  = 1'b1;
            flushM  = 1'b1;
            if (iWait) begin
                stallF         = 1'b1;
                branchPendNext = 1'b1;
            end
        end else if (eWait) begin
            stallF = 1'b1;
            stallD = 1'b1;
            stallE = 1'b1;
            flushM = 1'b1;
        end else if (branchD) begin
            flushF2 = 1'b1;
            flushD  = 1'b1;
            if (iWait) begin
                stallF       = 1'b1;
                jumpPendNext = 1'b1;
            end
        end else if (iWait) begin
            stallF  = 1'b1;
            flushF2 = 1'b1;
        end

        // The stale word shows up once the wait ends and is dropped here
        if (!iWait && excpPend) begin
            flushF2      = 1'b1;
            flushD       = 1'b1;
            excpPendNext = 1'b0;
        end
        if (!iWait && branchPend) begin
            flushF2        = 1'b1;
            flushD         = 1'b1;
            branchPendNext = 1'b0;
        end
        if (!iWait && jumpPend) begin
            flushF2      = 1'b1;
            flushD       = 1'b1;
            jumpPendNext = 1'b0;
        end
    end

endmodule

//--- src/memStage.sv
`timescale 1ns/1ps

module memStage (
    input  logic            clk,
    input  logic            reset,
    input  logic            stallM,
    input  logic            flushM,
    input  pipePkg::slot_t  slotIn,
    input  logic            dWaitIn,
    output pipePkg::slot_t  slotOut,
    output logic            branchM,
    output pipePkg::pc_t    targetM,
    output logic            dWait,
    output logic            excpM
);
    import pipePkg::*;

    ctrlFields_t ctrl;

    always_ff @(posedge clk) begin
        if (reset || flushM) begin
            slotOut <= bubbleSlot;
        end else if (!stallM) begin
            slotOut <= slotIn;
        end
    end

    assign ctrl = slotOut.instr.ctrl;

    // The condition bit stands in for a compare result
    assign branchM = slotOut.valid && (ctrl.opcode == BRANCH) && ctrl.cond;
    assign targetM = slotOut.pc + pc_t'(ctrl.offset);

    // Only a load talks to data memory, so only a load can be held here
    assign dWait = slotOut.valid && (ctrl.opcode == LOAD) && dWaitIn;
    assign excpM = slotOut.valid && (ctrl.opcode == TRAP);

endmodule

//--- src/pipePkg.sv
package pipePkg;

    localparam int pcWidth = 6;

    typedef logic [pcWidth-1:0] pc_t;

    // Restart address after a TRAP retires
    localparam pc_t trapVector = 6'h20;

    typedef enum logic [2:0] {
        ALU    = 3'd0,
        LOAD   = 3'd1,
        JUMP   = 3'd2,
        BRANCH = 3'd3,
        TRAP   = 3'd4
    } opcode_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [1:0]  latency;
        logic [26:0] unused;
    } aluFields_t;

    // Offset is relative to the instruction's own PC
    typedef struct packed {
        opcode_t            opcode;
        logic               cond;
        logic signed [5:0]  offset;
        logic [21:0]        unused;
    } ctrlFields_t;

    typedef union packed {
        aluFields_t  alu;
        ctrlFields_t ctrl;
    } instr_t;

    typedef struct packed {
        logic   valid;
        pc_t    pc;
        instr_t instr;
    } slot_t;

    localparam slot_t bubbleSlot = '0;

endpackage

//--- src/pipeTop.sv
`timescale 1ns/1ps

module pipeTop (
    input  logic             clk,
    input  logic             reset,
    input  logic             imemReqReady,
    input  logic             imemRespValid,
    input  pipePkg::instr_t  imemRespData,
    input  logic             dWaitIn,
    output logic             imemReqValid,
    output pipePkg::pc_t     imemReqAddr,
    output logic             commitValid,
    output pipePkg::pc_t     commitPc,
    output pipePkg::instr_t  commitInstr
);
    import pipePkg::*;

    slot_t slotF2;
    slot_t slotD;
    slot_t slotE;
    slot_t slotM;
    pc_t   targetD;
    pc_t   targetM;
    logic  branchD;
    logic  branchM;
    logic  excpM;
    logic  excpW;
    logic  iWait;
    logic  eWait;
    logic  dWait;
    logic  stallF;
    logic  flushF2;
    logic  stallD;
    logic  flushD;
    logic  stallE;
    logic  flushE;
    logic  stallM;
    logic  flushM;
    logic  flushW;

    fetchUnit uFetch (
        .clk(clk), .reset(reset), .stallF(stallF), .flushF2(flushF2),
        .redirectD(branchD), .targetD(targetD), .redirectM(branchM), .targetM(targetM),
        .redirectW(excpW), .imemReqValid(imemReqValid), .imemReqAddr(imemReqAddr),
        .imemReqReady(imemReqReady), .imemRespValid(imemRespValid),
        .imemRespData(imemRespData), .iWait(iWait), .slotF2(slotF2)
    );

    decodeStage uDecode (
        .clk(clk), .reset(reset), .stallD(stallD), .flushD(flushD), .slotIn(slotF2),
        .slotOut(slotD), .branchD(branchD), .targetD(targetD)
    );

    execStage uExec (
        .clk(clk), .reset(reset), .stallE(stallE), .flushE(flushE), .slotIn(slotD),
        .slotOut(slotE), .eWait(eWait)
    );

    memStage uMem (
        .clk(clk), .reset(reset), .stallM(stallM), .flushM(flushM), .slotIn(slotE),
        .dWaitIn(dWaitIn), .slotOut(slotM), .branchM(branchM), .targetM(targetM),
        .dWait(dWait), .excpM(excpM)
    );

    writebackStage uWriteback (
        .clk(clk), .reset(reset), .flushW(flushW), .slotIn(slotM),
        .commitValid(commitValid), .commitPc(commitPc), .commitInstr(commitInstr),
        .excpW(excpW)
    );

    hazardUnit uHazard (
        .clk(clk), .reset(reset), .branchD(branchD), .branchM(branchM), .excpM(excpM),
        .excpW(excpW), .iWait(iWait), .eWait(eWait), .dWait(dWait), .stallF(stallF),
        .flushF2(flushF2), .stallD(stallD), .flushD(flushD), .stallE(stallE),
        .flushE(flushE), .stallM(stallM), .flushM(flushM), .flushW(flushW)
    );

endmodule

//--- src/writebackStage.sv
`timescale 1ns/1ps

module writebackStage (
    input  logic             clk,
    input  logic             reset,
    input  logic             flushW,
    input  pipePkg::slot_t   slotIn,
    output logic             commitValid,
    output pipePkg::pc_t     commitPc,
    output pipePkg::instr_t  commitInstr,
    output logic             excpW
);
    import pipePkg::*;

    slot_t slotW;

    always_ff @(posedge clk) begin
        if (reset || flushW) begin
            slotW <= bubbleSlot;
        end else begin
            slotW <= slotIn;
        end
    end

    // A trap retires as a redirect and never shows up on the commit port
    assign excpW       = slotW.valid && (slotW.instr.ctrl.opcode == TRAP);
    assign commitValid = slotW.valid && (slotW.instr.ctrl.opcode != TRAP);
    assign commitPc    = slotW.pc;
    assign commitInstr = slotW.instr;

endmodule

//--- verif/fetchInput.mem
// Lines 0 to 47 hold the program image, one 32-bit instruction word per line
// The last 32 lines hold the expected commit PCs in commit order
00000000
00000001
20000002
00000003
20000004
40C00005 // jump to 08
80000006
00000007
18000008
18000009
2000000A
7100000B // taken branch to 0F
8000000C
0000000D
4000000E
6140000F // branch not taken
18000010
20000011
40800012
80000013
40800014
00000015
08000016
70C00017
00000018
20000019
2000001A
8000001B // trap to the vector at 20
0000001C
0000001D
4000001E
0000001F
00000020
10000021
20000022
41000023
80000024
00000025
00000026
60800027
18000028
20000029
4F80002A // jump back to 28
8000002B
0000002C
0000002D
0000002E
0000002F
// Expected commit PCs
00
01
02
03
04
05
08
09
0A
0B
0F
10
11
12
14
16
17
1A
20
21
22
23
27
28
29
2A
28
29
2A
28
29
2A

//--- verif/pipeTb.sv
`timescale 1ns/1ps

module pipeTb;
    import pipePkg::*;

    localparam int programWords    = 48;
    localparam int numCommits      = 32;
    localparam int fileWordCount   = programWords + numCommits;
    localparam int resetCycles     = 8;
    localparam int cyclesPerCommit = 40;
    localparam int timeoutCycles   = numCommits * cyclesPerCommit;

    logic   clk = 1'b0;
    logic   reset = 1'b1;
    logic   imemReqReady = 1'b0;
    logic   imemRespValid = 1'b0;
    instr_t imemRespData = '0;
    logic   dWaitIn = 1'b0;
    logic   imemReqValid;
    pc_t    imemReqAddr;
    logic   commitValid;
    pc_t    commitPc;
    instr_t commitInstr;

    logic [31:0] fileWords [0:fileWordCount-1];
    logic [31:0] imem [0:63];
    pc_t         expectedPc [0:numCommits-1];
    logic [31:0] lfsrState = 32'ha34c;

    logic       sampleAccept = 1'b0;
    pc_t        sampleAddr = '0;
    logic       memBusy = 1'b0;
    pc_t        respAddr = '0;
    logic [1:0] waitLeft = '0;

    int  resetCount = 0;
    int  cycleCount = 0;
    int  commitCount = 0;
    pc_t lastPc = '0;
    int  traceErrors = 0;
    int  wordErrors = 0;
    int  ruleErrors = 0;
    int  timeoutErrors = 0;

    pipeTop DUT (
        .clk(clk),
        .reset(reset),
        .imemReqReady(imemReqReady),
        .imemRespValid(imemRespValid),
        .imemRespData(imemRespData),
        .dWaitIn(dWaitIn),
        .imemReqValid(imemReqValid),
        .imemReqAddr(imemReqAddr),
        .commitValid(commitValid),
        .commitPc(commitPc),
        .commitInstr(commitInstr)
    );

    always #4 clk = ~clk;

    // Taps 32, 22, 2 and 1 give a maximal length sequence
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic drawBits(input int count, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[6:0], lfsrState[0]};
        end
    endtask

    // Program order successor before any trap is taken into account
    function automatic pc_t plainSuccessor(input pc_t pc);
        logic [31:0] word;
        word = imem[pc];
        if (word[31:29] == JUMP) begin
            return pc + word[27:22];
        end
        if (word[31:29] == BRANCH && word[28]) begin
            return pc + word[27:22];
        end
        return pc + 6'd1;
    endfunction

    function automatic pc_t successorPc(input pc_t pc);
        pc_t next;
        next = plainSuccessor(pc);
        if (imem[next][31:29] == TRAP) begin
            next = trapVector;
        end
        return next;
    endfunction

    function automatic string behaviorName(input pc_t pc);
        logic [31:0] word;
        word = imem[pc];
        if (imem[plainSuccessor(pc)][31:29] == TRAP) begin
            return "trapRedirect";
        end else if (word[31:29] == JUMP) begin
            return "jumpRedirect";
        end else if (word[31:29] == BRANCH) begin
            return "branchTaken";
        end
        return "straightLine";
    endfunction

    task automatic checkCommit(input pc_t pc, input logic [31:0] word);
        pc_t   predicted;
        string behavior;
        if (commitCount == 0) begin
            predicted = '0;
            behavior = "straightLine";
        end else begin
            predicted = successorPc(lastPc);
            behavior = behaviorName(lastPc);
        end
        if (pc !== expectedPc[commitCount]) begin
            $display("Fail redirectDuringWait: commit %0d expected pc %h, actual pc %h",
                     commitCount, expectedPc[commitCount], pc);
            traceErrors++;
        end
        if (pc !== predicted) begin
            $display("Fail %s: commit %0d expected pc %h, actual pc %h",
                     behavior, commitCount, predicted, pc);
            ruleErrors++;
        end
        if (word !== imem[pc]) begin
            $display("Fail multicycleOrder: pc %h expected word %h, actual word %h",
                     pc, imem[pc], word);
            wordErrors++;
        end
        if (word[31:29] == TRAP) begin
            $display("Error in trapRedirect: the TRAP at pc %h showed up on the commit port", pc);
            ruleErrors++;
        end
        lastPc = pc;
        commitCount++;
    endtask

    always @(posedge clk) begin
        if (resetCount != resetCycles) begin
            resetCount <= resetCount + 1;
        end
        reset <= (resetCount + 1 < resetCycles);
    end

    // DUT outputs are settled by the falling edge
    always @(negedge clk) begin
        sampleAccept = imemReqValid && imemReqReady;
        sampleAddr = imemReqAddr;
        if (!reset && commitValid && commitCount < numCommits) begin
            checkCommit(commitPc, commitInstr);
        end
    end

    // Instruction memory answers each accepted request 1 to 3 cycles later
    always @(posedge clk) begin
        logic [7:0] bits;
        if (reset) begin
            imemReqReady  <= 1'b0;
            imemRespValid <= 1'b0;
            dWaitIn       <= 1'b0;
            memBusy = 1'b0;
        end else begin
            cycleCount    <= cycleCount + 1;
            imemRespValid <= 1'b0;
            if (sampleAccept) begin
                if (memBusy) begin
                    $display("Error in fetch: request for pc %h was accepted while another was outstanding",
                             sampleAddr);
                    ruleErrors++;
                end
                drawBits(2, bits);
                memBusy  = 1'b1;
                respAddr = sampleAddr;
                waitLeft = (bits[1:0] == 2'd0) ? 2'd1 : bits[1:0];
            end
            if (memBusy && waitLeft == 2'd1) begin
                imemRespValid <= 1'b1;
                imemRespData  <= imem[respAddr];
                memBusy = 1'b0;
            end else if (memBusy) begin
                waitLeft = waitLeft - 2'd1;
            end
            drawBits(2, bits);
            imemReqReady <= (bits[1:0] != 2'd0);
            drawBits(2, bits);
            dWaitIn <= (bits[1:0] == 2'd3);
        end
    end

    initial begin
        $readmemh("verif/fetchInput.mem", fileWords);
        for (int i = 0; i < 64; i++) begin
            if (i < programWords) begin
                imem[i] = fileWords[i];
            end else begin
                // Unused space holds ALU words tagged with their address
                imem[i] = 32'h00ab_0000 + 32'(i);
            end
        end
        for (int j = 0; j < numCommits; j++) begin
            expectedPc[j] = pc_t'(fileWords[programWords + j]);
        end
        wait (commitCount == numCommits || cycleCount >= timeoutCycles);
        if (commitCount != numCommits) begin
            $display("Timeout: only %0d of %0d commits arrived within %0d cycles",
                     commitCount, numCommits, timeoutCycles);
            timeoutErrors = 1;
        end
        $display("Commits %0d, trace errors %0d, word errors %0d, order errors %0d, timeouts %0d",
                 commitCount, traceErrors, wordErrors, ruleErrors, timeoutErrors);
        if (traceErrors + wordErrors + ruleErrors + timeoutErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
